// File: fetchTestdata.txt
// word_waits_err_branch_flags_operand_nextaddr, one fetch per line
// branch = {jmp, jr, ccApply, ccSelect[1:0], ccInvert}, flags = {sign, carry, zero, parity}
A001_0_0_00_0_0000_0002
A002_1_0_00_F_1234_0004
A003_2_0_00_0_0000_0006
B010_0_0_20_0_0010_0016
B020_3_0_30_0_0100_0100
B030_1_0_20_0_FFF0_00F0
C001_0_0_08_2_0020_0110
C002_2_0_08_D_0020_0112
C003_0_0_09_0_0040_0152
C004_1_0_09_2_0040_0154
C005_0_0_0A_4_0008_015C
C006_3_0_0A_B_0008_015E
C007_0_0_0B_0_FFFE_015C
C008_1_0_0B_4_0100_015E
C009_0_0_0C_8_0200_035E
C00A_2_0_0C_7_0200_0360
C00B_0_0_0D_7_0010_0370
C00C_1_0_0D_8_0010_0372
C00D_0_0_0E_1_0004_0376
C00E_3_0_0E_E_0004_0378
C00F_0_0_0F_E_0006_037E
C010_2_0_0F_1_0006_0380
D001_0_0_30_0_FFFC_FFFC
D002_1_0_00_0_0000_FFFE
D003_0_0_00_0_0000_0000
E0E0_2_1_00_0_0000_0000

// File: src.f
+incdir+.
cpuPkg.sv
apbPkg.sv
nextPcLogic.sv
programCounter.sv
fetchSequencer.sv
instrLatch.sv
fetchUnit.sv
fetchUnitTb.sv

// File: fetchUnitTb.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module fetchUnitTb
	import cpuPkg::*;
	import apbPkg::*;
();

	localparam int numSteps  = 26;
	localparam int waitLimit = 20;

	// one line of the test data file with nibble aligned fields
	typedef struct packed {
		cpuWord     word;
		logic [3:0] waits;
		logic [3:0] err;
		logic [7:0] branchBits; // low 6 bits hold a branchCtl
		logic [3:0] flagBits;
		cpuWord     operand;
		pcAddr      nextAddr;
	} stepRec;

	logic     CLK;
	logic     rstN;
	apbReq    req;
	apbRsp    rsp;
	cpuWord   instr;
	pcAddr    instrAddr;
	logic     instrValid;
	logic     commit;
	branchCtl branch;
	ccFlags   flags;
	cpuWord   operand;
	logic     fault;

	logic [67:0] stepMem [0:numSteps-1];

	fetchUnit dut (
		.CLK        (CLK),
		.rstN       (rstN),
		.req        (req),
		.rsp        (rsp),
		.instr      (instr),
		.instrAddr  (instrAddr),
		.instrValid (instrValid),
		.commit     (commit),
		.branch     (branch),
		.flags      (flags),
		.operand    (operand),
		.fault      (fault)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	function automatic pcAddr calcNextPc(input pcAddr pc, input branchCtl br,
			input ccFlags fl, input cpuWord op);
		logic [3:0] byCode;
		logic       taken;
		byCode = {fl.parity, fl.sign, fl.carry, fl.zero}; // indexed by select code
		taken  = byCode[br.ccSelect] ^ br.ccInvert;
		if (br.jmp && br.jr == `JR_ABS) begin
			return op;
		end
		if (br.jmp || (br.ccApply && taken)) begin
			return pc + op;
		end
		return pc + `PC_STEP;
	endfunction

	task automatic reportMismatch(input string what, input logic [15:0] got,
			input logic [15:0] exp);
		$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		$display("Test failed");
		$fatal(1, "first mismatch stops the run");
	endtask

	task automatic reportTimeout(input string what);
		$display("timeout after %0d cycles waiting for %s", waitLimit, what);
		$display("Test failed");
		$fatal(1, "wait loop ran out of cycles");
	endtask

	task automatic checkAddr(input pcAddr got, input pcAddr exp, input string what);
		if (got !== exp) begin
			reportMismatch(what, got, exp);
		end
	endtask

	task automatic checkWord(input cpuWord got, input cpuWord exp, input string what);
		if (got !== exp) begin
			reportMismatch(what, got, exp);
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			reportMismatch(what, {15'd0, got}, {15'd0, exp});
		end
	endtask

	// samples at the edge see the cycle that just ended
	task automatic waitForSetup(input pcAddr expAddr);
		int cycles;
		cycles = 0;
		@(posedge CLK);
		while (!(req.psel && !req.penable)) begin
			if (cycles == waitLimit) begin
				reportTimeout("the APB setup phase");
			end
			cycles++;
			@(posedge CLK);
		end
		checkAddr(req.paddr, expAddr, "paddr in setup");
		checkFlag(instrValid, 1'b0, "instrValid in setup");
	endtask

	task automatic answerAccess(input stepRec rec, input pcAddr expAddr);
		logic [31:0] junk;
		int          w;
		for (w = 0; w < rec.waits; w++) begin
			@(posedge CLK);
			checkFlag(req.penable, 1'b1, "penable in wait state");
			checkAddr(req.paddr, expAddr, "paddr in wait state");
		end
		rsp.prdata  <= rec.word;
		rsp.pready  <= 1'b1;
		rsp.pslverr <= rec.err[0];
		@(posedge CLK);
		checkFlag(req.penable, 1'b1, "penable with pready");
		checkAddr(req.paddr, expAddr, "paddr with pready");
		junk = $urandom;
		rsp.prdata  <= junk[15:0]; // latch must not follow the bus after this
		rsp.pready  <= 1'b0;
		rsp.pslverr <= 1'b0;
	endtask

	task automatic commitStep(input stepRec rec, input pcAddr expAddr);
		logic [31:0] junk;
		int unsigned delay;
		int          cycles;
		int          d;
		cycles = 0;
		@(posedge CLK);
		while (!instrValid) begin
			if (cycles == waitLimit) begin
				reportTimeout("instrValid");
			end
			checkFlag(req.psel, 1'b0, "psel before commit");
			cycles++;
			@(posedge CLK);
		end
		checkWord(instr, rec.word, "instr");
		checkAddr(instrAddr, expAddr, "instrAddr");
		checkFlag(fault, 1'b0, "fault on good access");
		delay = $urandom % 4;
		for (d = 0; d < delay; d++) begin
			@(posedge CLK);
			checkFlag(instrValid, 1'b1, "instrValid under back-pressure");
			checkWord(instr, rec.word, "instr under back-pressure");
			checkAddr(instrAddr, expAddr, "instrAddr under back-pressure");
			checkFlag(req.psel, 1'b0, "psel before commit");
		end
		commit  <= 1'b1;
		branch  <= rec.branchBits[5:0];
		flags   <= rec.flagBits;
		operand <= rec.operand;
		@(posedge CLK);
		checkFlag(instrValid, 1'b1, "instrValid in commit cycle");
		checkFlag(req.psel, 1'b0, "psel in commit cycle");
		junk = $urandom;
		commit  <= 1'b0;
		branch  <= junk[5:0]; // don't care outside the commit cycle
		flags   <= junk[9:6];
		operand <= junk[31:16];
	endtask

	task automatic waitForFault();
		int cycles;
		int d;
		cycles = 0;
		@(posedge CLK);
		while (!fault) begin
			if (cycles == waitLimit) begin
				reportTimeout("fault after a slave error");
			end
			cycles++;
			@(posedge CLK);
		end
		checkFlag(instrValid, 1'b0, "instrValid after slave error");
		for (d = 0; d < 10; d++) begin
			@(posedge CLK);
			checkFlag(req.psel, 1'b0, "psel in fault state");
			checkFlag(fault, 1'b1, "fault held");
		end
	endtask

	initial begin
		stepRec rec;
		pcAddr  expAddr;
		pcAddr  calcAddr;
		logic   faultSeen;
		int     i;
		rstN      = 1'b0;
		commit    = 1'b0;
		branch    = '0;
		flags     = '0;
		operand   = '0;
		rsp       = '0;
		faultSeen = 1'b0;
		expAddr   = `RESET_PC;
		void'($urandom(88425));
		$readmemh("fetchTestdata.txt", stepMem);
		if ($isunknown(stepMem[numSteps-1])) begin
			$display("could not read %0d steps from fetchTestdata.txt", numSteps);
			$display("Test failed");
			$fatal(1, "missing test data");
		end
		repeat (5) @(posedge CLK);
		rstN <= 1'b1;

		for (i = 0; i < numSteps; i++) begin
			rec = stepMem[i];
			waitForSetup(expAddr);
			answerAccess(rec, expAddr);
			if (rec.err[0]) begin
				waitForFault();
				faultSeen = 1'b1;
				break;
			end
			// the file's next address must agree with the branch rule
			calcAddr = calcNextPc(expAddr, rec.branchBits[5:0], rec.flagBits, rec.operand);
			checkAddr(calcAddr, rec.nextAddr, "next address in test data");
			commitStep(rec, expAddr);
			expAddr = rec.nextAddr;
		end

		if (faultSeen) begin
			$display("Test passed");
			$finish;
		end else begin
			$display("test data ended without reaching the bus error step");
			$display("Test failed");
			$fatal(1, "no fault step");
		end
	end

endmodule

// File: fetchUnit.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module fetchUnit
	import cpuPkg::*;
	import apbPkg::*;
(
	input  logic     CLK,
	input  logic     rstN,

	// APB master port
	output apbReq    req,
	input  apbRsp    rsp,

	// execute stage port
	output cpuWord   instr,
	output pcAddr    instrAddr,
	output logic     instrValid,
	input  logic     commit,
	input  branchCtl branch,
	input  ccFlags   flags,
	input  cpuWord   operand,
	output logic     fault
);

	pcAddr pc;
	pcAddr nextPc;
	logic  capture;
	logic  load;

	fetchSequencer seq (
		.CLK        (CLK),
		.rstN       (rstN),
		.pc         (pc),
		.rsp        (rsp),
		.req        (req),
		.commit     (commit),
		.instrValid (instrValid),
		.capture    (capture),
		.load       (load),
		.fault      (fault)
	);

	programCounter pcReg (
		.CLK    (CLK),
		.rstN   (rstN),
		.load   (load),
		.nextPc (nextPc),
		.pc     (pc)
	);

	// branch inputs are sampled in the commit cycle
	nextPcLogic nextPcCalc (
		.pc      (pc),
		.branch  (branch),
		.flags   (flags),
		.operand (operand),
		.nextPc  (nextPc)
	);

	// address tag is the pc of the access in flight
	instrLatch latch (
		.CLK          (CLK),
		.rstN         (rstN),
		.capture      (capture),
		.releaseInstr (load),
		.rdata        (rsp.prdata),
		.addr         (pc),
		.instr        (instr),
		.instrAddr    (instrAddr),
		.instrValid   (instrValid)
	);

endmodule

// File: instrLatch.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module instrLatch
	import cpuPkg::*;
(
	input  logic   CLK,
	input  logic   rstN,
	input  logic   capture,
	input  logic   releaseInstr,
	input  cpuWord rdata,
	input  pcAddr  addr,
	output cpuWord instr,
	output pcAddr  instrAddr,
	output logic   instrValid
);

	cpuWord wordReg;
	pcAddr  addrReg;
	logic   validReg;

	// payload only changes on capture, so it holds through HOLD
	always_ff @(posedge CLK) begin
		if (capture) begin
			wordReg <= rdata;
			addrReg <= addr;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			validReg <= 1'b0;
		end else if (capture) begin
			validReg <= 1'b1;
		end else if (releaseInstr) begin
			validReg <= 1'b0; // dropped on the commit edge
		end
	end

	assign instr      = wordReg;
	assign instrAddr  = addrReg;
	assign instrValid = validReg;

endmodule

// File: fetchSequencer.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module fetchSequencer
	import cpuPkg::*;
	import apbPkg::*;
(
	input  logic  CLK,
	input  logic  rstN,
	input  pcAddr pc,
	input  apbRsp rsp,
	output apbReq req,
	input  logic  commit,
	input  logic  instrValid,
	output logic  capture,
	output logic  load,
	output logic  fault
);

	fetchState state;
	fetchState nextState;
	logic      accessDone;
	logic      accessOk;
	logic      accessErr;
	logic      commitOk;

	// end of the APB access phase
	assign accessDone = (state == ACCESS) && rsp.pready;
	assign accessOk   = accessDone && !rsp.pslverr;
	assign accessErr  = accessDone && rsp.pslverr;

	// commit counts only while the instruction is valid
	assign commitOk = (state == HOLD) && commit && instrValid;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			state <= IDLE;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			IDLE: begin
				nextState = SETUP; // one quiet cycle after reset
			end
			SETUP: begin
				nextState = ACCESS;
			end
			ACCESS: begin
				if (accessErr) begin
					nextState = FAULT;
				end else if (accessOk) begin
					nextState = HOLD;
				end
			end
			HOLD: begin
				// execute stage back-pressures by holding off commit
				if (commitOk) begin
					nextState = SETUP;
				end
			end
			FAULT: begin
				nextState = FAULT; // parked until reset
			end
			default: begin
				nextState = IDLE;
			end
		endcase
	end

	// bus phases come straight from the state, paddr from the counter
	always_comb begin
		req.psel    = (state == SETUP) || (state == ACCESS);
		req.penable = (state == ACCESS);
		req.paddr   = pc; // pc only moves in HOLD so it is stable per access
	end

	assign capture = accessOk;
	assign load    = commitOk;
	assign fault   = (state == FAULT);

endmodule

// File: programCounter.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module programCounter
	import cpuPkg::*;
(
	input  logic  CLK,
	input  logic  rstN,
	input  logic  load,
	input  pcAddr nextPc,
	output pcAddr pc
);

	pcAddr pcReg;

	// load only moves on an accepted commit
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			pcReg <= `RESET_PC;
		end else if (load) begin
			pcReg <= nextPc;
		end
	end

	assign pc = pcReg;

endmodule

// File: nextPcLogic.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module nextPcLogic
	import cpuPkg::*;
(
	input  pcAddr    pc,
	input  branchCtl branch,
	input  ccFlags   flags,
	input  cpuWord   operand,
	output pcAddr    nextPc
);

	logic  flagSel;
	logic  condTrue;
	pcAddr stepTarget;
	pcAddr relTarget;
	pcAddr absTarget;

	// pick the flag named by ccSelect
	always_comb begin
		flagSel = 1'b0;
		case (branch.ccSelect)
			`CC_SEL_Z: flagSel = flags.zero;
			`CC_SEL_C: flagSel = flags.carry;
			`CC_SEL_S: flagSel = flags.sign;
			`CC_SEL_P: flagSel = flags.parity;
			default:   flagSel = 1'b0;
		endcase
	end

	assign condTrue = flagSel ^ branch.ccInvert;

	// all sums wrap at 16 bits
	assign stepTarget = pc + `PC_STEP;
	assign relTarget  = pc + operand;
	assign absTarget  = operand;

	always_comb begin
		if (branch.jmp) begin
			if (branch.jr == `JR_ABS) begin
				nextPc = absTarget;
			end else begin
				nextPc = relTarget;
			end
		end else if (branch.ccApply && condTrue) begin
			nextPc = relTarget; // conditional branches are always relative
		end else begin
			nextPc = stepTarget;
		end
	end

endmodule

// File: apbPkg.sv
`include "cpu_consts.svh"

package apbPkg;

	import cpuPkg::*;

	// master to slave, reads only so no pwrite or pwdata
	typedef struct packed {
		logic  psel;
		logic  penable;
		pcAddr paddr;
	} apbReq;

	// slave to master
	typedef struct packed {
		cpuWord prdata;
		logic   pready;
		logic   pslverr;
	} apbRsp;

endpackage

// File: cpuPkg.sv
`include "cpu_consts.svh"

package cpuPkg;

	// instruction address
	typedef logic [`CPU_WORD_WIDTH-1:0] pcAddr;

	// instruction or operand word
	typedef logic [`CPU_WORD_WIDTH-1:0] cpuWord;

	// condition flags from the execute stage
	typedef struct packed {
		logic sign;
		logic carry;
		logic zero;
		logic parity;
	} ccFlags;

	// branch control for the committed instruction
	typedef struct packed {
		logic       jmp;      // unconditional jump
		logic       jr;       // JR_REL or JR_ABS
		logic       ccApply;  // conditional relative branch
		logic [1:0] ccSelect; // one of the CC_SEL codes
		logic       ccInvert;
	} branchCtl;

	// fetch FSM states
	typedef enum logic [2:0] {
		IDLE,
		SETUP,
		ACCESS,
		HOLD,
		FAULT
	} fetchState;

endpackage

// File: cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath width, instructions and addresses share it
`define CPU_WORD_WIDTH 16

// program counter after reset
`define RESET_PC 16'h0000

// sequential fetch advances one 16-bit word
`define PC_STEP 16'd2

// condition flag select codes
`define CC_SEL_Z 2'b00
`define CC_SEL_C 2'b01
`define CC_SEL_S 2'b10
`define CC_SEL_P 2'b11

// jump mode
`define JR_REL 1'b0
`define JR_ABS 1'b1

`endif
